// File: src/trace_pkg.sv
// trace port package with CSR access types, addresses and the priority level type
`default_nettype none

package trace_pkg;

  typedef logic [31:0] word;
  typedef logic [11:0] csr_addr_t;
  typedef logic [4:0] zimm_t;

  // funct3 encoding of the Zicsr instructions
  typedef enum logic [2:0] {
    CsrWrite    = 3'b001,
    CsrSet      = 3'b010,
    CsrClear    = 3'b011,
    CsrWriteImm = 3'b101,
    CsrSetImm   = 3'b110,
    CsrClearImm = 3'b111
  } csr_op_e;

  // custom machine read/write range
  localparam csr_addr_t FifoByteCsrAddr = 12'h7c0;
  localparam csr_addr_t BaudCsrAddr = 12'h7c1;

  // task priority levels
  localparam int PrioBits = 2;
  localparam int PrioNum = 2 ** PrioBits;

  // lower value means more urgent
  typedef logic [PrioBits-1:0] prio_t;

  // default queue of 16 entries
  localparam int FifoDepthBits = 4;
  typedef logic [FifoDepthBits-1:0] fifo_ptr_t;

  // clock cycles per serial bit after reset
  localparam int DefaultBaudDiv = 16;

endpackage

`default_nettype wire

// File: src/csr_reg.sv
// machine CSR with write, set and clear operations in register and immediate form
`timescale 1ns/1ps
`default_nettype none

module csr_reg #(
  parameter int CsrWidth = 32,
  parameter trace_pkg::csr_addr_t Addr = '0,
  parameter logic [CsrWidth-1:0] ResetValue = '0
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 csr_enable,
  input  trace_pkg::csr_addr_t csr_addr,
  input  trace_pkg::csr_op_e   csr_op,
  input  trace_pkg::word       rs1_data,
  input  trace_pkg::zimm_t     rs1_zimm,
  output trace_pkg::word       next_value,
  output trace_pkg::word       rd_data
);
  import trace_pkg::*;

  logic [CsrWidth-1:0] value;
  logic addr_hit;
  logic write_en;
  word  cur_word;
  word  operand;
  word  new_word;

  assign addr_hit = (csr_addr == Addr);
  assign write_en = csr_enable && addr_hit;
  assign cur_word = word'(value);

  always_comb begin
    if (csr_op inside {CsrWriteImm, CsrSetImm, CsrClearImm}) begin
      operand = word'(rs1_zimm);
    end else begin
      operand = rs1_data;
    end
  end

  always_comb begin
    case (csr_op)
      CsrWrite, CsrWriteImm: new_word = operand;
      CsrSet, CsrSetImm:     new_word = cur_word | operand;
      CsrClear, CsrClearImm: new_word = cur_word & ~operand;
      default:               new_word = cur_word;
    endcase
  end

  // value the register holds after this edge
  assign next_value = write_en ? word'(new_word[CsrWidth-1:0]) : cur_word;

  // old value goes back to the core
  assign rd_data = addr_hit ? cur_word : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      value <= ResetValue;
    end else if (write_en) begin
      value <= new_word[CsrWidth-1:0];
    end
  end

  // decoder upstream must only hand over Zicsr operations
  assert property (@(posedge clk_i) disable iff (reset_i)
    csr_enable |-> csr_op inside {CsrWrite, CsrSet, CsrClear,
                                  CsrWriteImm, CsrSetImm, CsrClearImm})
    else $error("csr_reg: illegal csr_op %0d", csr_op);

endmodule

`default_nettype wire

// File: src/frame_fifo.sv
// trace byte CSR, zero-stuffing frame encoder with per-level runs, and circular byte queue
`timescale 1ns/1ps
`default_nettype none

module frame_fifo #(
  parameter int FifoDepthBits = trace_pkg::FifoDepthBits
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 csr_enable,
  input  trace_pkg::csr_addr_t csr_addr,
  input  trace_pkg::csr_op_e   csr_op,
  input  trace_pkg::word       rs1_data,
  input  trace_pkg::zimm_t     rs1_zimm,
  input  trace_pkg::prio_t     level,
  input  logic                 next,
  output logic [7:0]           data,
  output logic                 have_next,
  output trace_pkg::word       rd_data
);
  import trace_pkg::*;

  localparam int Depth = 2 ** FifoDepthBits;

  typedef logic [FifoDepthBits-1:0] ptr_t;

  logic [7:0] queue [Depth];
  ptr_t       in_ptr;
  ptr_t       out_ptr;
  ptr_t       in_ptr_p1;
  ptr_t       in_ptr_p2;
  ptr_t       data_ptr;
  ptr_t       used;
  prio_t      prev_level;

  // nonzero bytes since frame start or last zero, per level
  logic [7:0] run [PrioNum];

  word        byte_value;
  logic       byte_wr;
  logic       open_frame;
  logic       close_frame;
  logic [1:0] n_wr;
  logic [7:0] wr_byte;
  logic [7:0] run_base;
  logic [7:0] run_next;
  logic [7:0] close_code;
  logic [7:0] data_code;

  csr_reg #(
    .CsrWidth  (8),
    .Addr      (FifoByteCsrAddr),
    .ResetValue(8'h00)
  ) byte_csr_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .rs1_data  (rs1_data),
    .rs1_zimm  (rs1_zimm),
    .next_value(byte_value),
    .rd_data   (rd_data)
  );

  assign byte_wr = csr_enable && (csr_addr == FifoByteCsrAddr);
  assign wr_byte = byte_value[7:0];

  // preemption opens a frame, return to a less urgent level closes one
  assign open_frame = (level < prev_level);
  assign close_frame = (level > prev_level);

  assign in_ptr_p1 = in_ptr + 1'b1;
  assign in_ptr_p2 = in_ptr + 2'd2;

  always_comb begin
    run_base = open_frame ? 8'd0 : run[level];
    close_code = run[prev_level] + 8'd1;
    // close code and delimiter go ahead of the data byte
    data_ptr = close_frame ? in_ptr_p2 : in_ptr;
    if (wr_byte == 8'h00) begin
      data_code = run_base + 8'd1;
      run_next = 8'd0;
    end else begin
      data_code = wr_byte;
      run_next = run_base + 8'd1;
    end
    n_wr = (close_frame ? 2'd2 : 2'd0) + (byte_wr ? 2'd1 : 2'd0);
  end

  always_ff @(posedge clk_i) begin
    if (close_frame) begin
      queue[in_ptr] <= close_code;
      queue[in_ptr_p1] <= 8'h00;
    end
    if (byte_wr) begin
      queue[data_ptr] <= data_code;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_ptr <= '0;
      out_ptr <= '0;
      prev_level <= prio_t'(PrioNum - 1);
      run <= '{default: '0};
    end else begin
      in_ptr <= in_ptr + ptr_t'(n_wr);
      if (next) begin
        out_ptr <= out_ptr + 1'b1;
      end
      prev_level <= level;
      if (byte_wr) begin
        run[level] <= run_next;
      end else if (open_frame) begin
        run[level] <= 8'd0;
      end
    end
  end

  assign data = queue[out_ptr];
  assign have_next = (in_ptr != out_ptr);
  assign used = in_ptr - out_ptr;

  // transmitter pulls only what is there
  assert property (@(posedge clk_i) disable iff (reset_i) next |-> have_next)
    else $error("frame_fifo: next while queue empty");

  // software outran the UART, queue would wrap onto unsent bytes
  assert property (@(posedge clk_i) disable iff (reset_i)
    (n_wr != 2'd0) |-> (int'(used) + int'(n_wr) < Depth + int'(next)))
    else $error("frame_fifo: queue overrun, %0d used, %0d written", used, n_wr);

endmodule

`default_nettype wire

// File: src/uart_tx.sv
// baud divisor CSR and 8N1 serial transmitter pulling bytes from the trace queue
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int DefaultBaudDiv = trace_pkg::DefaultBaudDiv
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 csr_enable,
  input  trace_pkg::csr_addr_t csr_addr,
  input  trace_pkg::csr_op_e   csr_op,
  input  trace_pkg::word       rs1_data,
  input  trace_pkg::zimm_t     rs1_zimm,
  input  logic [7:0]           data,
  input  logic                 have_next,
  output logic                 next,
  output logic                 tx,
  output trace_pkg::word       rd_data
);
  import trace_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StStart,
    StData,
    StStop
  } tx_state_e;

  tx_state_e   state;
  word         baud_value;
  logic [15:0] div_q;
  logic [15:0] bit_cnt;
  logic [2:0]  bit_idx;
  logic [7:0]  shift_q;
  logic        bit_end;
  logic        start_byte;

  csr_reg #(
    .CsrWidth  (16),
    .Addr      (BaudCsrAddr),
    .ResetValue(16'(DefaultBaudDiv))
  ) baud_csr_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .rs1_data  (rs1_data),
    .rs1_zimm  (rs1_zimm),
    .next_value(baud_value),
    .rd_data   (rd_data)
  );

  assign start_byte = (state == StIdle) && have_next;
  assign bit_end = (bit_cnt == div_q - 16'd1);

  // byte and divisor fixed for the whole character
  always_ff @(posedge clk_i) begin
    if (start_byte) begin
      shift_q <= data;
      div_q <= baud_value[15:0];
    end else if (bit_end && (state == StStart || state == StData)) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= StIdle;
      tx <= 1'b1;
      next <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
    end else begin
      next <= 1'b0;
      bit_cnt <= bit_end ? 16'd0 : bit_cnt + 16'd1;
      case (state)
        StIdle: begin
          bit_cnt <= '0;
          if (have_next) begin
            state <= StStart;
            tx <= 1'b0;
            next <= 1'b1;
          end
        end
        StStart: begin
          if (bit_end) begin
            state <= StData;
            tx <= shift_q[0];
            bit_idx <= '0;
          end
        end
        StData: begin
          if (bit_end) begin
            if (bit_idx == 3'd7) begin
              state <= StStop;
              tx <= 1'b1;
            end else begin
              tx <= shift_q[0];
              bit_idx <= bit_idx + 3'd1;
            end
          end
        end
        StStop: begin
          if (bit_end) begin
            state <= StIdle;
          end
        end
        default: state <= StIdle;
      endcase
    end
  end

  // line rests at mark between characters
  assert property (@(posedge clk_i) disable iff (reset_i) (state == StIdle) |-> tx)
    else $error("uart_tx: tx low while idle");

endmodule

`default_nettype wire

// File: src/trace_port.sv
// trace port top level joining frame encoder and UART transmitter on one CSR bus
`timescale 1ns/1ps
`default_nettype none

module trace_port #(
  parameter int FifoDepthBits = $bits(trace_pkg::fifo_ptr_t),
  parameter int DefaultBaudDiv = trace_pkg::DefaultBaudDiv
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 csr_enable,
  input  trace_pkg::csr_addr_t csr_addr,
  input  trace_pkg::csr_op_e   csr_op,
  input  trace_pkg::word       rs1_data,
  input  trace_pkg::zimm_t     rs1_zimm,
  input  trace_pkg::prio_t     level,
  output trace_pkg::word       csr_data_out,
  output logic                 tx
);
  import trace_pkg::*;

  logic [7:0] data;
  logic       have_next;
  logic       next;
  word        fifo_rd_data;
  word        uart_rd_data;

  frame_fifo #(
    .FifoDepthBits(FifoDepthBits)
  ) frame_fifo_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .rs1_data  (rs1_data),
    .rs1_zimm  (rs1_zimm),
    .level     (level),
    .next      (next),
    .data      (data),
    .have_next (have_next),
    .rd_data   (fifo_rd_data)
  );

  uart_tx #(
    .DefaultBaudDiv(DefaultBaudDiv)
  ) uart_tx_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .csr_enable(csr_enable),
    .csr_addr  (csr_addr),
    .csr_op    (csr_op),
    .rs1_data  (rs1_data),
    .rs1_zimm  (rs1_zimm),
    .data      (data),
    .have_next (have_next),
    .next      (next),
    .tx        (tx),
    .rd_data   (uart_rd_data)
  );

  // unaddressed blocks return zero
  assign csr_data_out = fifo_rd_data | uart_rd_data;

endmodule

`default_nettype wire

// File: tb/tb_trace_model.svh
// trace port reference model with frame encoding, CSR update, LCG and value compare
`ifndef TB_TRACE_MODEL_SVH
`define TB_TRACE_MODEL_SVH

typedef logic [8:0] trace_event_t;
typedef trace_event_t event_q_t[$];
typedef logic [7:0] byte_q_t[$];

// bit 8 set marks a level change, otherwise a byte write
function automatic byte_q_t encode_trace(input event_q_t events);
  byte_q_t    out;
  logic [7:0] runs [PrioNum];
  int         prev;
  int         lvl;
  logic [7:0] value;
  prev = PrioNum - 1;
  foreach (runs[i]) begin
    runs[i] = 8'd0;
  end
  foreach (events[i]) begin
    value = events[i][7:0];
    if (events[i][8]) begin
      lvl = int'(value);
      if (lvl < prev) begin
        runs[lvl] = 8'd0;
      end else if (lvl > prev) begin
        // finished frame ends with its code and a delimiter
        out.push_back(runs[prev] + 8'd1);
        out.push_back(8'h00);
      end
      prev = lvl;
    end else if (value == 8'h00) begin
      out.push_back(runs[prev] + 8'd1);
      runs[prev] = 8'd0;
    end else begin
      out.push_back(value);
      runs[prev] = runs[prev] + 8'd1;
    end
  end
  return out;
endfunction

// 16-bit divisor CSR after one access
function automatic logic [15:0] csr_update(input logic [15:0] old, input csr_op_e op,
                                           input word rs1, input zimm_t zimm);
  logic [15:0] operand;
  if (op == CsrWriteImm || op == CsrSetImm || op == CsrClearImm) begin
    operand = 16'(zimm);
  end else begin
    operand = rs1[15:0];
  end
  case (op)
    CsrWrite, CsrWriteImm: return operand;
    CsrSet, CsrSetImm:     return old | operand;
    default:               return old & ~operand;
  endcase
endfunction

function automatic logic [31:0] lcg_step(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_value(input string name, input word expected, input word actual);
  check_count++;
  if (expected !== actual) begin
    error_count++;
    $display("** Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
  end
endtask

`endif

// File: tb/tb_trace_port.sv
// testbench for the trace port, checking CSR accesses and the framed UART byte stream
`timescale 1ns/1ps
`default_nettype none

module tb_trace_port;
  import trace_pkg::*;

  localparam int ClkPeriod = 100;
  localparam int MarginCycles = 400;

  int error_count;
  int check_count;

  `include "tb_trace_model.svh"

  logic         clk_i;
  logic         reset_i;
  logic         csr_enable;
  csr_addr_t    csr_addr;
  csr_op_e      csr_op;
  word          rs1_data;
  zimm_t        rs1_zimm;
  prio_t        level;
  word          csr_data_out;
  logic         tx;
  int           test_count;
  int           test_errors;
  int           checked;
  int           cur_div;
  int           wait_cycles;
  int           wait_limit;
  logic         waiting;
  logic [31:0]  lcg_state;
  logic [7:0]   last_byte;
  string        test_name;
  trace_event_t events[$];
  logic [7:0]   rx_q[$];

  trace_port trace_port_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .csr_enable  (csr_enable),
    .csr_addr    (csr_addr),
    .csr_op      (csr_op),
    .rs1_data    (rs1_data),
    .rs1_zimm    (rs1_zimm),
    .level       (level),
    .csr_data_out(csr_data_out),
    .tx          (tx)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // bounded wait for the expected bytes of a test
  always @(posedge clk_i) begin
    if (waiting) begin
      wait_cycles = wait_cycles + 1;
      if (wait_cycles > wait_limit) begin
        $display("UART stopped sending in test %s after %0d cycles", test_name, wait_cycles);
        $display("sim failed");
        $finish;
      end
    end
  end

  // sample each bit at mid-period from the start edge
  always begin : line_decoder
    int         bit_time;
    logic [7:0] rx_byte;
    @(negedge tx);
    bit_time = cur_div * ClkPeriod;
    #(bit_time / 2);
    if (tx !== 1'b0) begin
      error_count++;
      $display("start bit on the serial line was too short in test %s", test_name);
    end else begin
      for (int i = 0; i < 8; i++) begin
        #(bit_time);
        rx_byte[i] = tx;
      end
      #(bit_time);
      if (tx !== 1'b1) begin
        error_count++;
        $display("stop bit missing on the serial line in test %s", test_name);
      end
      rx_q.push_back(rx_byte);
    end
  end

  function automatic word draw_word();
    lcg_state = lcg_step(lcg_state);
    return lcg_state;
  endfunction

  function automatic logic [7:0] draw_byte(input logic allow_zero);
    word r;
    r = draw_word();
    if (allow_zero && r[1:0] == 2'b00) begin
      return 8'h00;
    end
    return (r[23:16] == 8'h00) ? 8'ha5 : r[23:16];
  endfunction

  task automatic csr_access(input csr_addr_t addr, input csr_op_e op, input word rs1,
                            input zimm_t zimm, output word rd);
    @(negedge clk_i);
    csr_enable = 1'b1;
    csr_addr = addr;
    csr_op = op;
    rs1_data = rs1;
    rs1_zimm = zimm;
    #(ClkPeriod / 4);
    rd = csr_data_out;
    @(negedge clk_i);
    csr_enable = 1'b0;
  endtask

  task automatic write_byte(input logic [7:0] value);
    word rd;
    csr_access(FifoByteCsrAddr, CsrWrite, word'(value), '0, rd);
    // byte CSR reads back the byte written before
    check_value($sformatf("%s byte csr read", test_name), word'(last_byte), rd);
    last_byte = value;
    events.push_back({1'b0, value});
  endtask

  task automatic set_level(input prio_t new_level);
    @(negedge clk_i);
    level = new_level;
    events.push_back({1'b1, 8'(new_level)});
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = error_count;
    test_count++;
  endtask

  task automatic finish_test();
    byte_q_t expected;
    expected = encode_trace(events);
    wait_cycles = 0;
    wait_limit = (expected.size() - rx_q.size()) * 10 * cur_div + MarginCycles;
    waiting = 1'b1;
    while (rx_q.size() < expected.size()) begin
      @(posedge clk_i);
    end
    waiting = 1'b0;
    check_value({test_name, " byte count"}, expected.size(), rx_q.size());
    for (int i = checked; i < expected.size() && i < rx_q.size(); i++) begin
      check_value($sformatf("%s byte %0d", test_name, i), expected[i], rx_q[i]);
    end
    checked = expected.size();
    $display("test %0d %s finished, %0d errors", test_count, test_name,
             error_count - test_errors);
  endtask

  task automatic check_idle_line();
    int low_count;
    low_count = 0;
    start_test("idle line");
    repeat (64) begin
      @(negedge clk_i);
      if (tx !== 1'b1) begin
        low_count++;
      end
    end
    check_value("idle line low samples", 32'd0, low_count);
    finish_test();
  endtask

  task automatic exercise_csr_ops();
    csr_op_e     ops[6];
    logic [15:0] model;
    word         rs1;
    word         rd;
    ops = '{CsrWrite, CsrSet, CsrClear, CsrWriteImm, CsrSetImm, CsrClearImm};
    start_test("csr ops");
    model = 16'(DefaultBaudDiv);
    foreach (ops[i]) begin
      rs1 = draw_word();
      csr_access(BaudCsrAddr, ops[i], rs1, zimm_t'(rs1[12:8]), rd);
      check_value({test_name, " ", ops[i].name()}, word'(model), rd);
      model = csr_update(model, ops[i], rs1, zimm_t'(rs1[12:8]));
    end
    csr_access(12'h7c5, CsrSet, '0, '0, rd);
    check_value("csr ops unmapped read", 32'd0, rd);
    // divisor back to its reset value before any byte goes out
    csr_access(BaudCsrAddr, CsrWrite, word'(DefaultBaudDiv), '0, rd);
    check_value("csr ops last read", word'(model), rd);
    finish_test();
  endtask

  task automatic send_plain_frame();
    int n;
    start_test("single frame");
    set_level(prio_t'(2));
    n = 3 + int'(draw_word() % 4);
    repeat (n) begin
      write_byte(draw_byte(1'b0));
    end
    set_level(prio_t'(PrioNum - 1));
    finish_test();
  endtask

  task automatic send_stuffed_frame();
    int zero_pos;
    start_test("zero stuffing");
    zero_pos = int'(draw_word() % 8);
    set_level(prio_t'(1));
    for (int i = 0; i < 8; i++) begin
      write_byte((i == zero_pos) ? 8'h00 : draw_byte(1'b1));
    end
    set_level(prio_t'(PrioNum - 1));
    finish_test();
  endtask

  task automatic send_nested_frames();
    start_test("preemption");
    set_level(prio_t'(2));
    repeat (3) begin
      write_byte(draw_byte(1'b1));
    end
    set_level(prio_t'(0));
    repeat (3) begin
      write_byte(draw_byte(1'b1));
    end
    // outer frame picks up its saved run
    set_level(prio_t'(2));
    repeat (2) begin
      write_byte(draw_byte(1'b1));
    end
    set_level(prio_t'(PrioNum - 1));
    finish_test();
  endtask

  task automatic change_baud_rate();
    int  new_div;
    word rd;
    start_test("baud change");
    new_div = 8 + int'(draw_word() % 8);
    csr_access(BaudCsrAddr, CsrWrite, word'(new_div), '0, rd);
    check_value("baud change old divisor", word'(cur_div), rd);
    cur_div = new_div;
    set_level(prio_t'(1));
    repeat (5) begin
      write_byte(draw_byte(1'b1));
    end
    set_level(prio_t'(PrioNum - 1));
    finish_test();
  endtask

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    csr_enable = 1'b0;
    csr_addr = '0;
    csr_op = CsrWrite;
    rs1_data = '0;
    rs1_zimm = '0;
    level = prio_t'(PrioNum - 1);
    error_count = 0;
    check_count = 0;
    test_count = 0;
    checked = 0;
    cur_div = DefaultBaudDiv;
    waiting = 1'b0;
    last_byte = 8'h00;
    test_name = "reset";
    lcg_state = 32'h1fbe;
    repeat (3) begin
      @(negedge clk_i);
    end
    reset_i = 1'b0;

    check_idle_line();
    exercise_csr_ops();
    send_plain_frame();
    send_stuffed_frame();
    send_nested_frames();
    change_baud_rate();

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+tb
src/trace_pkg.sv
src/csr_reg.sv
src/frame_fifo.sv
src/uart_tx.sv
src/trace_port.sv
tb/tb_trace_port.sv
